/* Bender.yml */
package:
  name: regfile_2w4r

sources:
  # RTL in compile order
  - files:
      - src/regfile_pkg.sv
      - src/regfile_bank_ram.sv
      - src/live_value_table.sv
      - src/read_port_mux.sv
      - src/regfile_2w4r.sv

  # Verification sources
  - target: test
    files:
      - verification/regfile_2w4r_sva.sv
      - verification/regfile_2w4r_tb.sv

/* regfile_2w4r.f */
src/regfile_pkg.sv
src/regfile_bank_ram.sv
src/live_value_table.sv
src/read_port_mux.sv
src/regfile_2w4r.sv
verification/regfile_2w4r_sva.sv
verification/regfile_2w4r_tb.sv

/* src/live_value_table.sv */
`timescale 1ns/10ps

// Live value table for the two-bank register file
// One flag per register tells which bank holds the newest copy
// A flag of 0 points at bank 0 and a flag of 1 points at bank 1

module live_value_table import regfile_pkg::*; (
  input  logic              clka,
  input  logic              rst,
  input  logic              wr0,
  input  logic              wr1,
  input  logic [REG_AW-1:0] wa0,
  input  logic [REG_AW-1:0] wa1,
  input  logic [REG_AW-1:0] ra0,
  input  logic [REG_AW-1:0] ra1,
  input  logic [REG_AW-1:0] ra2,
  input  logic [REG_AW-1:0] ra3,
  output logic [NREAD-1:0]  live_bank
);

  // Bank select flag of every register
  logic [NREG-1:0] live;

  // ==========================================================================
  // Flag update
  // ==========================================================================

  // Port 0 clears the flag of its target and port 1 sets the flag of its own
  // The port 1 assignment comes last, so when both ports hit the same
  // register in one cycle the flag ends up set and port 1 wins
  // The byte mask plays no part here, a partial write still moves the flag
  always_ff @(posedge clka or posedge rst) begin
    if (rst) begin
      // After reset every register is read from bank 0
      live <= '0;
    end else begin
      if (wr0) begin
        live[wa0] <= 1'b0;
      end
      if (wr1) begin
        live[wa1] <= 1'b1;
      end
    end
  end

  // ==========================================================================
  // Flag lookup
  // ==========================================================================

  // One lookup per read port, combinational like the bank reads
  assign live_bank[0] = live[ra0];
  assign live_bank[1] = live[ra1];
  assign live_bank[2] = live[ra2];
  assign live_bank[3] = live[ra3];

endmodule

/* src/read_port_mux.sv */
`timescale 1ns/10ps

// Output selection of one read port
// The special registers take priority over the bank data, and for an
// ordinary register the live value flag picks the bank

module read_port_mux import regfile_pkg::*; (
  input  logic [REG_AW-1:0] ra,
  input  logic [WID-1:0]    pc,
  input  logic [WID-1:0]    bank0_data,
  input  logic [WID-1:0]    bank1_data,
  input  logic              live_bank,
  output logic [WID-1:0]    o
);

  // Decoded special addresses
  logic is_zero;
  logic is_pc;

  assign is_zero = (ra == REG_AW'(REG_ZERO));
  assign is_pc   = (ra == REG_AW'(REG_PC));

  // ==========================================================================
  // Selection
  // ==========================================================================

  always_comb begin
    if (is_zero) begin
      // Hardwired zero register
      o = '0;
    end else if (is_pc) begin
      // Program counter of the lane that owns this port
      o = pc;
    end else if (live_bank) begin
      // Write port 1 was the last to touch this register
      o = bank1_data;
    end else begin
      // Write port 0 was last, or nothing has written it since reset
      o = bank0_data;
    end
  end

endmodule

/* src/regfile_2w4r.sv */
`timescale 1ns/10ps

// Two-write, four-read integer register file
// Each write port owns one bank, and the live value table steers every read
// to the bank that was written last, so the write ports never conflict

module regfile_2w4r import regfile_pkg::*; (
  input  logic              clka,
  input  logic              rst,
  input  logic [WID-1:0]    pc0,
  input  logic [WID-1:0]    pc1,
  input  logic              wr0,
  input  logic              wr1,
  input  logic [NBYTE-1:0]  we0,
  input  logic [NBYTE-1:0]  we1,
  input  logic [REG_AW-1:0] wa0,
  input  logic [REG_AW-1:0] wa1,
  input  logic [WID-1:0]    i0,
  input  logic [WID-1:0]    i1,
  input  logic [REG_AW-1:0] ra0,
  input  logic [REG_AW-1:0] ra1,
  input  logic [REG_AW-1:0] ra2,
  input  logic [REG_AW-1:0] ra3,
  output logic [WID-1:0]    o0,
  output logic [WID-1:0]    o1,
  output logic [WID-1:0]    o2,
  output logic [WID-1:0]    o3
);

  // Read data of bank 0 and bank 1, one word per read port
  logic [WID-1:0] b0_o0, b0_o1, b0_o2, b0_o3;
  logic [WID-1:0] b1_o0, b1_o1, b1_o2, b1_o3;

  // Bank select of each read port from the live value table
  logic [NREAD-1:0] live_bank;

  // ==========================================================================
  // Banks
  // ==========================================================================

  // Bank 0 is written only by port 0
  regfile_bank_ram u_bank0 (
    .clka (clka), .wr (wr0), .we (we0), .wa (wa0), .i (i0),
    .ra0  (ra0), .ra1 (ra1), .ra2 (ra2), .ra3 (ra3),
    .o0   (b0_o0), .o1 (b0_o1), .o2 (b0_o2), .o3 (b0_o3)
  );

  // Bank 1 is written only by port 1
  regfile_bank_ram u_bank1 (
    .clka (clka), .wr (wr1), .we (we1), .wa (wa1), .i (i1),
    .ra0  (ra0), .ra1 (ra1), .ra2 (ra2), .ra3 (ra3),
    .o0   (b1_o0), .o1 (b1_o1), .o2 (b1_o2), .o3 (b1_o3)
  );

  // Both write ports feed the table, which records the last writer
  live_value_table u_lvt (
    .clka (clka), .rst (rst),
    .wr0  (wr0), .wr1 (wr1), .wa0 (wa0), .wa1 (wa1),
    .ra0  (ra0), .ra1 (ra1), .ra2 (ra2), .ra3 (ra3),
    .live_bank (live_bank)
  );

  // ==========================================================================
  // Read ports
  // ==========================================================================

  // Ports 0 and 1 belong to issue lane 0
  read_port_mux u_rd0 (.ra (ra0), .pc (pc0), .bank0_data (b0_o0),
    .bank1_data (b1_o0), .live_bank (live_bank[0]), .o (o0));
  read_port_mux u_rd1 (.ra (ra1), .pc (pc0), .bank0_data (b0_o1),
    .bank1_data (b1_o1), .live_bank (live_bank[1]), .o (o1));

  // Ports 2 and 3 belong to issue lane 1
  read_port_mux u_rd2 (.ra (ra2), .pc (pc1), .bank0_data (b0_o2),
    .bank1_data (b1_o2), .live_bank (live_bank[2]), .o (o2));
  read_port_mux u_rd3 (.ra (ra3), .pc (pc1), .bank0_data (b0_o3),
    .bank1_data (b1_o3), .live_bank (live_bank[3]), .o (o3));

endmodule

/* src/regfile_bank_ram.sv */
`timescale 1ns/10ps

// One storage bank of the register file
// A bank keeps a full copy of all registers and is written by exactly one
// write port, so no bank ever sees two writes in the same cycle

module regfile_bank_ram import regfile_pkg::*; (
  input  logic              clka,
  input  logic              wr,
  input  logic [NBYTE-1:0]  we,
  input  logic [REG_AW-1:0] wa,
  input  logic [WID-1:0]    i,
  input  logic [REG_AW-1:0] ra0,
  input  logic [REG_AW-1:0] ra1,
  input  logic [REG_AW-1:0] ra2,
  input  logic [REG_AW-1:0] ra3,
  output logic [WID-1:0]    o0,
  output logic [WID-1:0]    o1,
  output logic [WID-1:0]    o2,
  output logic [WID-1:0]    o3
);

  // ==========================================================================
  // Storage
  // ==========================================================================

  // Small and read combinationally, so it maps onto LUT RAM
  (* ram_style = "distributed" *)
  logic [WID-1:0] mem [0:NREG-1];

  // Start simulation with every register cleared
  // The contents are never touched by rst
  initial begin
    for (int n = 0; n < NREG; n++) begin
      mem[n] = '0;
    end
  end

  // ==========================================================================
  // Write port
  // ==========================================================================

  // Each enabled byte lane takes the new data at the edge
  // Lanes that are not enabled keep whatever this bank held before
  always @(posedge clka) begin
    if (wr) begin
      for (int b = 0; b < NBYTE; b++) begin
        if (we[b]) begin
          mem[wa][b*(WID/NBYTE) +: (WID/NBYTE)] <= i[b*(WID/NBYTE) +: (WID/NBYTE)];
        end
      end
    end
  end

  // ==========================================================================
  // Read ports
  // ==========================================================================

  // Purely combinational reads with no write bypass
  // A register being written this cycle still shows its old value here
  assign o0 = mem[ra0];
  assign o1 = mem[ra1];
  assign o2 = mem[ra2];
  assign o3 = mem[ra3];

endmodule

/* src/regfile_pkg.sv */
// ==========================================================================
// Register file sizes and special register numbers
// ==========================================================================

package regfile_pkg;

  // Width of one architectural register in bits
  localparam int WID = 64;

  // Byte lanes per register, and so the width of every byte-enable mask
  localparam int NBYTE = 8;

  // Number of architectural registers held in each bank
  localparam int NREG = 64;

  // Width of a register address
  localparam int REG_AW = 6;

  // Number of read ports, which is also the read port count of each bank
  localparam int NREAD = 4;

  // ==========================================================================
  // Special registers
  // ==========================================================================

  // Register 0 is hardwired to zero on every read port
  localparam int REG_ZERO = 0;

  // Register 53 returns the program counter of the issue lane that owns the
  // read port, so the core can form PC-relative operands without a move
  localparam int REG_PC = 53;

  // Writes to either special register still land in the banks
  // They are simply never visible through a read port

endpackage

/* verification/regfile_2w4r_sva.sv */
`timescale 1ns/10ps

// Port-level properties of the register file, bound to every instance

module regfile_2w4r_sva import regfile_pkg::*; (
  input logic              clka,
  input logic              rst,
  input logic [WID-1:0]    pc0,
  input logic [WID-1:0]    pc1,
  input logic [REG_AW-1:0] ra0,
  input logic [REG_AW-1:0] ra1,
  input logic [REG_AW-1:0] ra2,
  input logic [REG_AW-1:0] ra3,
  input logic [WID-1:0]    o0,
  input logic [WID-1:0]    o1,
  input logic [WID-1:0]    o2,
  input logic [WID-1:0]    o3
);

  // Count of assertion failures over the whole run
  int fail_count;

  // Register 0 is hardwired to zero
  property zero_reads_zero(logic [REG_AW-1:0] ra, logic [WID-1:0] o);
    @(posedge clka) disable iff (rst) (ra == REG_AW'(REG_ZERO)) |-> (o == {WID{1'b0}});
  endproperty

  // Register 53 follows the program counter of the port's lane
  property pc_reads_lane_pc(logic [REG_AW-1:0] ra, logic [WID-1:0] o, logic [WID-1:0] pc);
    @(posedge clka) disable iff (rst) (ra == REG_AW'(REG_PC)) |-> (o == pc);
  endproperty

  a_zero0: assert property (zero_reads_zero(ra0, o0)) else begin
    fail_count++;
    $error("Port 0 register 0 not zero");
  end
  a_zero1: assert property (zero_reads_zero(ra1, o1)) else begin
    fail_count++;
    $error("Port 1 register 0 not zero");
  end
  a_zero2: assert property (zero_reads_zero(ra2, o2)) else begin
    fail_count++;
    $error("Port 2 register 0 not zero");
  end
  a_zero3: assert property (zero_reads_zero(ra3, o3)) else begin
    fail_count++;
    $error("Port 3 register 0 not zero");
  end

  // Ports 0 and 1 sit on lane 0, ports 2 and 3 on lane 1
  a_pc0: assert property (pc_reads_lane_pc(ra0, o0, pc0)) else begin
    fail_count++;
    $error("Port 0 PC read wrong");
  end
  a_pc1: assert property (pc_reads_lane_pc(ra1, o1, pc0)) else begin
    fail_count++;
    $error("Port 1 PC read wrong");
  end
  a_pc2: assert property (pc_reads_lane_pc(ra2, o2, pc1)) else begin
    fail_count++;
    $error("Port 2 PC read wrong");
  end
  a_pc3: assert property (pc_reads_lane_pc(ra3, o3, pc1)) else begin
    fail_count++;
    $error("Port 3 PC read wrong");
  end

  // No read port may carry X or Z once reset is released
  a_known: assert property (@(posedge clka) disable iff (rst) !$isunknown({o0, o1, o2, o3}))
    else begin
      fail_count++;
      $error("Read data unknown after reset");
    end

endmodule

bind regfile_2w4r regfile_2w4r_sva u_sva (
  .clka (clka), .rst (rst), .pc0 (pc0), .pc1 (pc1),
  .ra0  (ra0), .ra1 (ra1), .ra2 (ra2), .ra3 (ra3),
  .o0   (o0), .o1 (o1), .o2 (o2), .o3 (o3)
);

/* verification/regfile_2w4r_tb.sv */
`timescale 1ns/10ps

module regfile_2w4r_tb import regfile_pkg::*; ();

  localparam time CLK_PERIOD    = 4ns;
  // Reset, then the cycles of each directed test in run order
  localparam int  TEST_CYCLES   = 5 + NREG / 4 + 2 + 5 + 2 + 7 + 5;
  localparam int  MARGIN_CYCLES = 60;

  logic              clka, rst;
  logic [WID-1:0]    pc0, pc1;
  logic              wr0, wr1;
  logic [NBYTE-1:0]  we0, we1;
  logic [REG_AW-1:0] wa0, wa1;
  logic [WID-1:0]    i0, i1;
  logic [REG_AW-1:0] ra0, ra1, ra2, ra3;
  logic [WID-1:0]    o0, o1, o2, o3;

  // Reference model with one copy of every register per bank and the last-writer flags
  logic [WID-1:0] bank0_m [NREG];
  logic [WID-1:0] bank1_m [NREG];
  logic           live_m  [NREG];

  regfile_2w4r DUT (.*);

  initial begin
    clka = 1'b0;
    forever #(CLK_PERIOD / 2) clka = ~clka;
  end

  // ==========================================================================
  // Model and checks
  // ==========================================================================

  // Enabled byte lanes take the new data, the rest keep the old word
  function automatic logic [WID-1:0] merge_bytes(logic [WID-1:0] old_word,
                                                  logic [WID-1:0] data, logic [NBYTE-1:0] mask);
    logic [WID-1:0] r;
    r = old_word;
    for (int b = 0; b < NBYTE; b++) begin
      if (mask[b]) r[b*8 +: 8] = data[b*8 +: 8];
    end
    return r;
  endfunction

  // Zero register, lane PC, or the bank the flag points at
  function automatic logic [WID-1:0] expected_read(logic [REG_AW-1:0] addr, logic [WID-1:0] pc);
    if (addr == REG_AW'(REG_ZERO)) return '0;
    if (addr == REG_AW'(REG_PC)) return pc;
    return live_m[addr] ? bank1_m[addr] : bank0_m[addr];
  endfunction

  function automatic logic [WID-1:0] rand_word();
    return {$urandom, $urandom};
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_reg(input string name, input logic [WID-1:0] got,
                           input logic [WID-1:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // One write cycle on both ports, starting at a falling edge
  // The strobes drop again at the next falling edge, after exactly one write edge
  task automatic write_regs(input logic w0, input logic [NBYTE-1:0] m0,
                            input logic [REG_AW-1:0] a0, input logic [WID-1:0] d0,
                            input logic w1, input logic [NBYTE-1:0] m1,
                            input logic [REG_AW-1:0] a1, input logic [WID-1:0] d1);
    wr0 = w0;
    we0 = m0;
    wa0 = a0;
    i0  = d0;
    wr1 = w1;
    we1 = m1;
    wa1 = a1;
    i1  = d1;
    if (w0) begin
      bank0_m[a0] = merge_bytes(bank0_m[a0], d0, m0);
      live_m[a0]  = 1'b0;
    end
    // Port 1 applied last so it wins a same-register collision
    if (w1) begin
      bank1_m[a1] = merge_bytes(bank1_m[a1], d1, m1);
      live_m[a1]  = 1'b1;
    end
    @(negedge clka);
    wr0 = 1'b0;
    wr1 = 1'b0;
  endtask

  // Drive four addresses and sample just before the next falling edge
  task automatic check_reads(input logic [REG_AW-1:0] a0, input logic [REG_AW-1:0] a1,
                             input logic [REG_AW-1:0] a2, input logic [REG_AW-1:0] a3);
    ra0 = a0;
    ra1 = a1;
    ra2 = a2;
    ra3 = a3;
    @(posedge clka);
    #1;
    // Ports 0 and 1 see lane 0's PC, ports 2 and 3 see lane 1's
    check_reg("o0", o0, expected_read(a0, pc0));
    check_reg("o1", o1, expected_read(a1, pc0));
    check_reg("o2", o2, expected_read(a2, pc1));
    check_reg("o3", o3, expected_read(a3, pc1));
    @(negedge clka);
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================

  task automatic test_reset_reads();
    for (int a = 0; a < NREG; a += 4) begin
      check_reads(REG_AW'(a), REG_AW'(a + 1), REG_AW'(a + 2), REG_AW'(a + 3));
    end
  endtask

  task automatic test_dual_write();
    write_regs(1'b1, '1, 6'd5, rand_word(), 1'b1, '1, 6'd9, rand_word());
    check_reads(6'd5, 6'd9, 6'd9, 6'd5);
  endtask

  task automatic test_overwrite();
    write_regs(1'b1, '1, 6'd12, rand_word(), 1'b0, '0, 6'd0, '0);
    write_regs(1'b0, '0, 6'd0, '0, 1'b1, '1, 6'd12, rand_word());
    check_reads(6'd12, 6'd12, 6'd12, 6'd12);
    write_regs(1'b1, '1, 6'd12, rand_word(), 1'b0, '0, 6'd0, '0);
    check_reads(6'd12, 6'd12, 6'd12, 6'd12);
  endtask

  task automatic test_same_reg();
    write_regs(1'b1, '1, 6'd20, rand_word(), 1'b1, '1, 6'd20, rand_word());
    check_reads(6'd20, 6'd20, 6'd20, 6'd20);
  endtask

  // Bank 1 still holds zero for register 30, so port 1's partial write picks that up
  task automatic test_partial();
    write_regs(1'b1, '1, 6'd30, rand_word(), 1'b0, '0, 6'd0, '0);
    write_regs(1'b1, 8'h0f, 6'd30, rand_word(), 1'b0, '0, 6'd0, '0);
    check_reads(6'd30, 6'd30, 6'd30, 6'd30);
    write_regs(1'b0, '0, 6'd0, '0, 1'b1, 8'hf0, 6'd30, rand_word());
    check_reads(6'd30, 6'd30, 6'd30, 6'd30);
    write_regs(1'b1, 8'h3c, 6'd30, rand_word(), 1'b0, '0, 6'd0, '0);
    check_reads(6'd30, 6'd30, 6'd30, 6'd30);
  endtask

  task automatic test_special_regs();
    write_regs(1'b1, '1, REG_AW'(REG_ZERO), rand_word(), 1'b1, '1, REG_AW'(REG_PC), rand_word());
    write_regs(1'b1, '1, REG_AW'(REG_PC), rand_word(), 1'b1, '1, REG_AW'(REG_ZERO), rand_word());
    check_reads(REG_AW'(REG_PC), REG_AW'(REG_PC), REG_AW'(REG_PC), REG_AW'(REG_PC));
    // Move both lane PCs so the next reads show the current values
    pc0 = rand_word();
    pc1 = rand_word();
    check_reads(REG_AW'(REG_PC), REG_AW'(REG_ZERO), REG_AW'(REG_ZERO), REG_AW'(REG_PC));
    check_reads(REG_AW'(REG_ZERO), REG_AW'(REG_ZERO), REG_AW'(REG_ZERO), REG_AW'(REG_ZERO));
  endtask

  // ==========================================================================
  // Sequencing
  // ==========================================================================

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Run timed out before all tests finished");
    $display("Some tests failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    void'($urandom(32'h06f41396));
    rst = 1'b1;
    pc0 = 64'h0000_0000_0000_1000;
    pc1 = 64'h0000_0000_0000_2000;
    wr0 = 1'b0;
    we0 = '0;
    wa0 = '0;
    i0  = '0;
    wr1 = 1'b0;
    we1 = '0;
    wa1 = '0;
    i1  = '0;
    ra0 = '0;
    ra1 = '0;
    ra2 = '0;
    ra3 = '0;
    // Model banks start cleared like the RAM, flags cleared like the table
    for (int n = 0; n < NREG; n++) begin
      bank0_m[n] = '0;
      bank1_m[n] = '0;
      live_m[n]  = 1'b0;
    end
    repeat (5) @(posedge clka);
    @(negedge clka);
    rst = 1'b0;
    test_reset_reads();
    test_dual_write();
    test_overwrite();
    test_same_reg();
    test_partial();
    test_special_regs();
    // A failed assertion in the bound checker also fails the run
    if (DUT.u_sva.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
